/* logic/iob_bus_consts.svh */
`ifndef IOB_BUS_CONSTS_SVH
`define IOB_BUS_CONSTS_SVH

// Bus geometry
`define IOB_ADDR_W 32
`define IOB_DATA_W 32

// Number of followers behind the split
`define IOB_N_FOLLOWERS 2

// Address bit that picks the follower
// 0 selects the RAM, 1 selects the control registers
`define IOB_SEL_BIT 12

// RAM word address width, 256 words
`define IOB_RAM_AW 8

// Value returned by the read-only ID register
`define IOB_CTRL_ID 32'hC7A1_0001

`endif

/* logic/iob_bus_pkg.sv */
`default_nettype none

`include "iob_bus_consts.svh"

package iob_bus_pkg;

   // Byte address
   typedef logic [`IOB_ADDR_W-1:0] addr_t;

   // Data word and its byte strobes
   typedef logic [`IOB_DATA_W-1:0]   data_t;
   typedef logic [`IOB_DATA_W/8-1:0] strb_t;

   // Follower index
   typedef logic [$clog2(`IOB_N_FOLLOWERS)-1:0] sel_t;

   // Request toward a follower, zero wstrb means read
   typedef struct packed {
      logic  avalid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } iob_req_t;

   // Read response, ready travels on its own wire
   typedef struct packed {
      data_t rdata;
      logic  rvalid;
   } iob_resp_t;

endpackage

`default_nettype wire

/* logic/iob_req_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

// One-entry request buffer between the master port and the split
module iob_req_buffer (
   input  wire                        clk_i,
   input  wire                        rst_n_i,

   // Master side
   input  wire iob_bus_pkg::iob_req_t m_req_i,
   output logic                       m_ready_o,

   // Split side
   output iob_bus_pkg::iob_req_t      s_req_o,
   input  wire                        s_ready_i
);

   logic                  valid_q;
   iob_bus_pkg::iob_req_t entry_q;

   // Room for a new request when empty or when the entry leaves this cycle
   assign m_ready_o = !valid_q || s_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (m_ready_o) begin
         valid_q <= m_req_i.avalid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (m_ready_o && m_req_i.avalid) begin
         entry_q <= m_req_i;
      end
   end

   // Entry fields go out as stored, avalid comes from the valid flag
   always_comb begin
      s_req_o        = entry_q;
      s_req_o.avalid = valid_q;
   end

   // A stalled request must not change until the split takes it
   a_hold_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (s_req_o.avalid && !s_ready_i) |=> $stable(s_req_o)
   );

endmodule

`default_nettype wire

/* logic/iob_split.sv */
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_consts.svh"

// Splits one IOb master across the followers, decoded on one address bit
module iob_split (
   input  wire                         clk_i,
   input  wire                         rst_n_i,

   // Master side
   input  wire iob_bus_pkg::iob_req_t  m_req_i,
   output logic                        m_ready_o,
   output iob_bus_pkg::iob_resp_t      m_resp_o,

   // Follower side
   output iob_bus_pkg::iob_req_t       f_req_o   [`IOB_N_FOLLOWERS],
   input  wire [`IOB_N_FOLLOWERS-1:0]  f_ready_i,
   input  wire iob_bus_pkg::iob_resp_t f_resp_i  [`IOB_N_FOLLOWERS]
);

   iob_bus_pkg::sel_t sel;
   iob_bus_pkg::sel_t sel_q;
   logic              accept;

   // Follower decode straight from the request address
   assign sel       = iob_bus_pkg::sel_t'(m_req_i.addr[`IOB_SEL_BIT]);
   assign m_ready_o = f_ready_i[sel];
   assign accept    = m_req_i.avalid && m_ready_o;

   // Address and write data fan out to all, avalid only to the decoded one
   always_comb begin
      for (int i = 0; i < `IOB_N_FOLLOWERS; i++) begin
         f_req_o[i]        = m_req_i;
         f_req_o[i].avalid = m_req_i.avalid && (sel == iob_bus_pkg::sel_t'(i));
      end
   end

   // Remember which follower took the last request
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sel_q <= '0;
      end else if (accept) begin
         sel_q <= sel;
      end
   end

   // Every follower answers in the cycle after acceptance,
   // so the stored selection points at the responder
   assign m_resp_o = f_resp_i[sel_q];

   for (genvar g = 0; g < `IOB_N_FOLLOWERS; g++) begin : g_resp_chk
      // Only the follower last accepted may answer
      a_resp_from_sel: assert property (
         @(posedge clk_i) disable iff (!rst_n_i)
         f_resp_i[g].rvalid |-> (sel_q == iob_bus_pkg::sel_t'(g))
      );
   end

   // A response always follows a read accepted one cycle earlier
   a_resp_after_read: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      m_resp_o.rvalid |-> $past(accept && (m_req_i.wstrb == '0))
   );

   // A write never produces a response
   a_no_write_resp: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (accept && (m_req_i.wstrb != '0)) |=> !m_resp_o.rvalid
   );

endmodule

`default_nettype wire

/* logic/iob_ram_follower.sv */
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_consts.svh"

// 256-word RAM follower with byte strobes and no wait states
module iob_ram_follower (
   input  wire                        clk_i,
   input  wire                        rst_n_i,
   input  wire iob_bus_pkg::iob_req_t req_i,
   output logic                       ready_o,
   output iob_bus_pkg::iob_resp_t     resp_o
);

   localparam int NBYTES = `IOB_DATA_W / 8;
   localparam int DEPTH  = 2 ** `IOB_RAM_AW;

   iob_bus_pkg::data_t     mem [DEPTH];
   logic [`IOB_RAM_AW-1:0] word_addr;
   logic                   rd_en;
   iob_bus_pkg::data_t     rdata_q;
   logic                   rvalid_q;

   // Always ready, every request is taken when presented
   assign ready_o   = 1'b1;
   assign word_addr = req_i.addr[`IOB_RAM_AW+1:2];
   assign rd_en     = req_i.avalid && (req_i.wstrb == '0);

   // Byte lane writes
   always_ff @(posedge clk_i) begin
      if (req_i.avalid) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (req_i.wstrb[b]) begin
               mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // Registered read word
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= mem[word_addr];
      end
   end

   // One cycle of rvalid per read
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   always_comb begin
      resp_o.rdata  = rdata_q;
      resp_o.rvalid = rvalid_q;
   end

endmodule

`default_nettype wire

/* logic/iob_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_consts.svh"

// Control register bank, three scratch words and an ID word
// Each access takes two cycles
module iob_ctrl_regs (
   input  wire                        clk_i,
   input  wire                        rst_n_i,
   input  wire iob_bus_pkg::iob_req_t req_i,
   output logic                       ready_o,
   output iob_bus_pkg::iob_resp_t     resp_o
);

   localparam int         NBYTES    = `IOB_DATA_W / 8;
   localparam int         N_SCRATCH = 3;
   localparam logic [1:0] ID_IDX    = 2'd3;

   typedef enum logic {
      CTRL_WAIT,
      CTRL_ACK
   } ctrl_state_e;

   ctrl_state_e        state_q;
   iob_bus_pkg::data_t scratch_q [N_SCRATCH];
   logic [1:0]         reg_idx;
   logic               accept;
   iob_bus_pkg::data_t rdata_q;
   logic               rvalid_q;

   assign reg_idx = req_i.addr[3:2];
   assign ready_o = (state_q == CTRL_ACK);
   assign accept  = req_i.avalid && ready_o;

   // First cycle of a request waits, second cycle acknowledges
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= CTRL_WAIT;
      end else if (state_q == CTRL_WAIT && req_i.avalid) begin
         state_q <= CTRL_ACK;
      end else begin
         state_q <= CTRL_WAIT;
      end
   end

   // Scratch registers, the ID slot drops writes
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < N_SCRATCH; i++) begin
            scratch_q[i] <= '0;
         end
      end else if (accept && (reg_idx != ID_IDX)) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (req_i.wstrb[b]) begin
               scratch_q[reg_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept && (req_i.wstrb == '0)) begin
         rdata_q <= (reg_idx == ID_IDX) ? `IOB_CTRL_ID : scratch_q[reg_idx];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= accept && (req_i.wstrb == '0);
      end
   end

   always_comb begin
      resp_o.rdata  = rdata_q;
      resp_o.rvalid = rvalid_q;
   end

   // Response never lands during an acknowledge cycle
   a_resp_timing: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      resp_o.rvalid |-> !ready_o
   );

endmodule

`default_nettype wire

/* logic/iob_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_consts.svh"

// IOb subsystem top, master port through a buffer and split to two followers
module iob_bus_top (
   input  wire                     clk_i,
   input  wire                     rst_n_i,

   // Master port
   input  wire                     avalid_i,
   input  wire iob_bus_pkg::addr_t addr_i,
   input  wire iob_bus_pkg::data_t wdata_i,
   input  wire iob_bus_pkg::strb_t wstrb_i,
   output iob_bus_pkg::data_t      rdata_o,
   output logic                    rvalid_o,
   output logic                    ready_o
);

   iob_bus_pkg::iob_req_t     m_req;
   iob_bus_pkg::iob_req_t     buf_req;
   logic                      buf_ready;
   iob_bus_pkg::iob_resp_t    m_resp;
   iob_bus_pkg::iob_req_t     f_req  [`IOB_N_FOLLOWERS];
   wire [`IOB_N_FOLLOWERS-1:0] f_ready;
   iob_bus_pkg::iob_resp_t    f_resp [`IOB_N_FOLLOWERS];

   // Pack the master signals at the boundary
   always_comb begin
      m_req.avalid = avalid_i;
      m_req.addr   = addr_i;
      m_req.wdata  = wdata_i;
      m_req.wstrb  = wstrb_i;
   end

   assign rdata_o  = m_resp.rdata;
   assign rvalid_o = m_resp.rvalid;

   iob_req_buffer i_req_buffer (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .m_req_i  (m_req),
      .m_ready_o(ready_o),
      .s_req_o  (buf_req),
      .s_ready_i(buf_ready)
   );

   iob_split i_split (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .m_req_i  (buf_req),
      .m_ready_o(buf_ready),
      .m_resp_o (m_resp),
      .f_req_o  (f_req),
      .f_ready_i(f_ready),
      .f_resp_i (f_resp)
   );

   // Follower 0, RAM region
   iob_ram_follower i_ram (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (f_req[0]),
      .ready_o(f_ready[0]),
      .resp_o (f_resp[0])
   );

   // Follower 1, control register region
   iob_ctrl_regs i_ctrl (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (f_req[1]),
      .ready_o(f_ready[1]),
      .resp_o (f_resp[1])
   );

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

// Free-running clock and a power-on reset held for a fixed number of cycles
module tb_clk_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      // Release on a falling edge, away from the flops' active edge
      @(negedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

/* tests/tb_iob_bus.sv */
`timescale 1ns/100ps
`default_nettype none

`include "iob_bus_consts.svh"

module tb_iob_bus;

   localparam int                 RESET_CYCLES = 8;
   localparam int                 CYCLES_PER_OP = 20;
   localparam iob_bus_pkg::addr_t CTRL_BASE = 32'h1 << `IOB_SEL_BIT;

   // One bus operation, zero wstrb means read
   typedef struct packed {
      iob_bus_pkg::addr_t addr;
      iob_bus_pkg::data_t wdata;
      iob_bus_pkg::strb_t wstrb;
      iob_bus_pkg::data_t rdata;
      logic               no_gap;
   } op_t;

   logic               clk;
   logic               rst_n;
   logic               avalid;
   iob_bus_pkg::addr_t addr;
   iob_bus_pkg::data_t wdata;
   iob_bus_pkg::strb_t wstrb;
   iob_bus_pkg::data_t rdata;
   logic               rvalid;
   logic               ready;

   op_t                ops [$];
   string              names [$];
   iob_bus_pkg::data_t exp_q [$];
   string              exp_name_q [$];
   logic               table_ready = 1'b0;
   int unsigned        lcg_state = 12;
   int                 checks = 0;
   int                 data_errors = 0;
   int                 proto_errors = 0;

   tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
      .clk_o  (clk),
      .rst_n_o(rst_n)
   );

   iob_bus_top i_dut (
      .clk_i   (clk),
      .rst_n_i (rst_n),
      .avalid_i(avalid),
      .addr_i  (addr),
      .wdata_i (wdata),
      .wstrb_i (wstrb),
      .rdata_o (rdata),
      .rvalid_o(rvalid),
      .ready_o (ready)
   );

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;
   endfunction

   task automatic add_write(input string name, input iob_bus_pkg::addr_t a,
                            input iob_bus_pkg::data_t d, input iob_bus_pkg::strb_t s);
      ops.push_back('{addr: a, wdata: d, wstrb: s, rdata: '0, no_gap: 1'b0});
      names.push_back(name);
   endtask

   task automatic add_read(input string name, input iob_bus_pkg::addr_t a,
                           input iob_bus_pkg::data_t e, input logic no_gap);
      ops.push_back('{addr: a, wdata: '0, wstrb: '0, rdata: e, no_gap: no_gap});
      names.push_back(name);
   endtask

   // Expected read data follows from the byte strobe rule, worked out per entry
   task automatic build_table();
      add_write("ram_w_full", 32'h010, 32'h1234_5678, 4'hF);
      add_read("ram_r_full", 32'h010, 32'h1234_5678, 1'b0);
      add_write("ram_w_top", 32'h3FC, 32'hDEAD_BEEF, 4'hF);
      add_read("ram_r_top", 32'h3FC, 32'hDEAD_BEEF, 1'b0);
      // Byte merging on one RAM word
      add_write("ram_w_base", 32'h020, 32'h1122_3344, 4'hF);
      add_write("ram_w_b0", 32'h020, 32'hAAAA_AAAA, 4'b0001);
      add_write("ram_w_b32", 32'h020, 32'hBBCC_DDEE, 4'b1100);
      add_read("ram_r_merge1", 32'h020, 32'hBBCC_33AA, 1'b0);
      add_write("ram_w_b21", 32'h020, 32'h0055_6600, 4'b0110);
      add_read("ram_r_merge2", 32'h020, 32'hBB55_66AA, 1'b0);
      // Control registers
      add_read("ctl_r_reset", CTRL_BASE + 32'h0, 32'h0, 1'b0);
      add_write("ctl_w_s0", CTRL_BASE + 32'h0, 32'h0000_00A0, 4'hF);
      add_write("ctl_w_s1", CTRL_BASE + 32'h4, 32'h0000_00A4, 4'hF);
      add_write("ctl_w_s2", CTRL_BASE + 32'h8, 32'hCAFE_F00D, 4'hF);
      add_read("ctl_r_s0", CTRL_BASE + 32'h0, 32'h0000_00A0, 1'b0);
      add_read("ctl_r_s1", CTRL_BASE + 32'h4, 32'h0000_00A4, 1'b0);
      add_read("ctl_r_s2", CTRL_BASE + 32'h8, 32'hCAFE_F00D, 1'b0);
      add_write("ctl_w_s2_b1", CTRL_BASE + 32'h8, 32'h0000_1100, 4'b0010);
      add_read("ctl_r_s2_b1", CTRL_BASE + 32'h8, 32'hCAFE_110D, 1'b0);
      add_write("ctl_w_id", CTRL_BASE + 32'hC, 32'hFFFF_FFFF, 4'hF);
      add_read("ctl_r_id", CTRL_BASE + 32'hC, `IOB_CTRL_ID, 1'b0);
      // Same offset in both regions
      add_write("dec_w_ram", 32'h004, 32'hA5A5_0004, 4'hF);
      add_write("dec_w_ctl", CTRL_BASE + 32'h4, 32'h5A5A_1004, 4'hF);
      add_read("dec_r_ram", 32'h004, 32'hA5A5_0004, 1'b0);
      add_read("dec_r_ctl", CTRL_BASE + 32'h4, 32'h5A5A_1004, 1'b0);
      // Back-to-back reads alternating between regions
      add_read("b2b_ram0", 32'h010, 32'h1234_5678, 1'b1);
      add_read("b2b_ctl0", CTRL_BASE + 32'h0, 32'h0000_00A0, 1'b1);
      add_read("b2b_ram1", 32'h020, 32'hBB55_66AA, 1'b1);
      add_read("b2b_ctl1", CTRL_BASE + 32'h8, 32'hCAFE_110D, 1'b1);
      add_read("b2b_ram2", 32'h3FC, 32'hDEAD_BEEF, 1'b1);
      add_read("b2b_ctl2", CTRL_BASE + 32'hC, `IOB_CTRL_ID, 1'b1);
      add_read("b2b_ram3", 32'h004, 32'hA5A5_0004, 1'b1);
      add_read("b2b_ctl3", CTRL_BASE + 32'h4, 32'h5A5A_1004, 1'b0);
   endtask

   task automatic finish_run();
      $display("Read checks %0d, data errors %0d, protocol errors %0d",
               checks, data_errors, proto_errors);
      if (data_errors == 0 && proto_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   initial begin : driver
      op_t op;
      int  gap;
      avalid = 1'b0;
      addr   = '0;
      wdata  = '0;
      wstrb  = '0;
      build_table();
      table_ready = 1'b1;
      wait (rst_n === 1'b1);
      repeat (2) @(posedge clk);
      for (int i = 0; i < ops.size(); i++) begin
         op = ops[i];
         avalid <= 1'b1;
         addr   <= op.addr;
         wdata  <= op.wdata;
         wstrb  <= op.wstrb;
         @(negedge clk);
         while (!ready) @(negedge clk);
         // Accepted on the coming edge
         if (op.wstrb == '0) begin
            exp_q.push_back(op.rdata);
            exp_name_q.push_back(names[i]);
         end
         @(posedge clk);
         gap = op.no_gap ? 0 : int'(lcg_next() % 3);
         if (gap > 0) begin
            avalid <= 1'b0;
            wstrb  <= '0;
            repeat (gap) @(posedge clk);
         end
      end
      avalid <= 1'b0;
      wstrb  <= '0;
      while (exp_q.size() != 0) @(negedge clk);
      repeat (4) @(negedge clk);
      finish_run();
   end

   // Reset values, then master ready once reset is released
   initial begin : reset_monitor
      @(negedge clk);
      while (!rst_n) begin
         assert (rvalid == 1'b0) else begin
            $display("rvalid_o went high while reset was asserted");
            proto_errors++;
         end
         @(negedge clk);
      end
      assert (ready == 1'b1 && rvalid == 1'b0) else begin
         $display("ready_o low or rvalid_o high right after reset release");
         proto_errors++;
      end
   end

   initial begin : resp_monitor
      iob_bus_pkg::data_t exp;
      string              nm;
      forever begin
         @(negedge clk);
         if (rst_n && rvalid) begin
            if (exp_q.size() == 0) begin
               $display("Read response arrived with no read outstanding, rdata %h", rdata);
               proto_errors++;
            end else begin
               exp = exp_q.pop_front();
               nm  = exp_name_q.pop_front();
               checks++;
               assert (rdata == exp) else begin
                  $display("CHECK FAILED %s expected %h actual %h", nm, exp, rdata);
                  data_errors++;
               end
            end
         end
      end
   end

   initial begin : watchdog
      int limit;
      wait (table_ready);
      limit = ops.size() * CYCLES_PER_OP + RESET_CYCLES;
      repeat (limit) @(posedge clk);
      $display("Timeout after %0d cycles, the operation sequence did not complete", limit);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/iob_bus_pkg.sv
logic/iob_req_buffer.sv
logic/iob_split.sv
logic/iob_ram_follower.sv
logic/iob_ctrl_regs.sv
logic/iob_bus_top.sv
tests/tb_clk_gen.sv
tests/tb_iob_bus.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the IOb bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
   --top-module tb_iob_bus -o tb_iob_bus_sim || exit 1

sim_out="$(./obj_dir/tb_iob_bus_sim)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qF "Simulation PASSED" && exit 0 || exit 1
